// ==== include/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define WORD_WIDTH     16
`define REG_ADDR_WIDTH 3
`define RESET_PC       16'h0000

// Opcodes live in bits 15 to 11.
`define OPC_HALT  5'b00000
`define OPC_NOP   5'b00001
`define OPC_J     5'b00100
`define OPC_ADDI  5'b01000
`define OPC_BEQZ  5'b01100
`define OPC_RTYPE 5'b11011

`define FUNCT_ADD 2'b00
`define FUNCT_SUB 2'b01
`define FUNCT_AND 2'b10
`define FUNCT_XOR 2'b11

`endif

// ==== logic/core_pkg.sv ====
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    typedef struct packed {
        logic [4:0]                   opcode;
        logic [`REG_ADDR_WIDTH-1:0]   rs;
        logic [`REG_ADDR_WIDTH-1:0]   rt;
        logic [`REG_ADDR_WIDTH-1:0]   rd;
        logic [1:0]                   funct;
    } r_view_t;

    typedef struct packed {
        logic [4:0]                   opcode;
        logic [`REG_ADDR_WIDTH-1:0]   rs;
        logic [`REG_ADDR_WIDTH-1:0]   rd;
        logic [4:0]                   imm;
    } i_view_t;

    // Decode reads each instruction word as R-type or as I-type.
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

    // The low two bits of the R-type operations equal the funct codes.
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_AND    = 5'd2,
        ALU_XOR    = 5'd3,
        ALU_PASS_B = 5'd4
    } alu_op_e;

endpackage

`default_nettype wire

// ==== logic/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic [`WORD_WIDTH-1:0]      wb_adr,
    input  wire logic                   wb_ack,
    input  wire logic [`WORD_WIDTH-1:0] wb_dat_i,
    output logic                        retire_valid,
    output logic [`REG_ADDR_WIDTH-1:0]  retire_reg,
    output logic [`WORD_WIDTH-1:0]      retire_data,
    output logic                        halted
);
    import core_pkg::*;

    instr_u                     instr;
    logic                       instr_valid;
    logic [`WORD_WIDTH-1:0]     pc;
    logic                       redirect;
    logic [`WORD_WIDTH-1:0]     redirect_pc;
    logic                       halt_seen;
    logic [`WORD_WIDTH-1:0]     read1;
    logic [`WORD_WIDTH-1:0]     read2;
    logic                       control_zero;

    logic [`WORD_WIDTH-1:0]     id_pc, id_read1, id_read2, id_imm, id_jumpaddr;
    logic [1:0]                 id_funct;
    logic [`REG_ADDR_WIDTH-1:0] id_write_reg, id_rs, id_rt, id_rd;
    alu_op_e                    id_alu_op;
    logic                       id_alu_src, id_branch, id_reg_write, id_jump, id_halt;
    logic                       id_rs_valid, id_rt_valid;

    logic [`WORD_WIDTH-1:0]     ex_pc, ex_read1, ex_read2, ex_imm, ex_jumpaddr;
    logic [1:0]                 ex_funct;
    logic [`REG_ADDR_WIDTH-1:0] ex_write_reg, ex_rs, ex_rt, ex_rd;
    alu_op_e                    ex_alu_op;
    logic                       ex_alu_src, ex_branch, ex_reg_write, ex_jump, ex_halt;
    logic                       ex_rs_valid, ex_rt_valid;

    fetch_wb i_fetch_wb (
        .clk(clk), .rst(rst), .wb_ack(wb_ack), .wb_dat_i(wb_dat_i),
        .redirect(redirect), .redirect_pc(redirect_pc), .halt_seen(halt_seen),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .instr(instr), .instr_valid(instr_valid), .pc(pc)
    );

    decode i_decode (
        .instr(instr), .instr_valid(instr_valid), .pc(pc), .redirect(redirect),
        .read1(read1), .read2(read2), .rs(id_rs), .rt(id_rt),
        .id_pc(id_pc), .id_read1(id_read1), .id_read2(id_read2), .id_imm(id_imm),
        .id_jumpaddr(id_jumpaddr), .id_funct(id_funct), .id_write_reg(id_write_reg),
        .id_alu_op(id_alu_op), .id_alu_src(id_alu_src), .id_branch(id_branch),
        .id_reg_write(id_reg_write), .id_jump(id_jump), .id_halt(id_halt), .id_rd(id_rd),
        .id_rs_valid(id_rs_valid), .id_rt_valid(id_rt_valid), .control_zero(control_zero)
    );

    reg_file i_reg_file (
        .clk(clk), .rst(rst), .rs(id_rs), .rt(id_rt),
        .we(retire_valid), .waddr(retire_reg), .wdata(retire_data),
        .read1(read1), .read2(read2)
    );

    idex_reg i_idex_reg (
        .clk(clk), .rst(rst), .control_zero(control_zero),
        .id_pc(id_pc), .id_read1(id_read1), .id_read2(id_read2), .id_imm(id_imm),
        .id_jumpaddr(id_jumpaddr), .id_funct(id_funct), .id_write_reg(id_write_reg),
        .id_alu_op(id_alu_op), .id_alu_src(id_alu_src), .id_branch(id_branch),
        .id_reg_write(id_reg_write), .id_jump(id_jump), .id_halt(id_halt),
        .id_rs(id_rs), .id_rt(id_rt), .id_rd(id_rd),
        .id_rs_valid(id_rs_valid), .id_rt_valid(id_rt_valid),
        .ex_pc(ex_pc), .ex_read1(ex_read1), .ex_read2(ex_read2), .ex_imm(ex_imm),
        .ex_jumpaddr(ex_jumpaddr), .ex_funct(ex_funct), .ex_write_reg(ex_write_reg),
        .ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_branch(ex_branch),
        .ex_reg_write(ex_reg_write), .ex_jump(ex_jump), .ex_halt(ex_halt),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
        .ex_rs_valid(ex_rs_valid), .ex_rt_valid(ex_rt_valid)
    );

    execute i_execute (
        .clk(clk), .rst(rst),
        .ex_pc(ex_pc), .ex_read1(ex_read1), .ex_read2(ex_read2), .ex_imm(ex_imm),
        .ex_jumpaddr(ex_jumpaddr), .ex_funct(ex_funct), .ex_write_reg(ex_write_reg),
        .ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_branch(ex_branch),
        .ex_reg_write(ex_reg_write), .ex_jump(ex_jump), .ex_halt(ex_halt),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
        .ex_rs_valid(ex_rs_valid), .ex_rt_valid(ex_rt_valid),
        .redirect(redirect), .redirect_pc(redirect_pc), .halt_seen(halt_seen),
        .halted(halted), .retire_valid(retire_valid), .retire_reg(retire_reg),
        .retire_data(retire_data)
    );

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode (
    input  core_pkg::instr_u                instr,
    input  wire logic                       instr_valid,
    input  wire logic [`WORD_WIDTH-1:0]     pc,
    input  wire logic                       redirect,
    input  wire logic [`WORD_WIDTH-1:0]     read1,
    input  wire logic [`WORD_WIDTH-1:0]     read2,
    output logic [`REG_ADDR_WIDTH-1:0]      rs,
    output logic [`REG_ADDR_WIDTH-1:0]      rt,
    output logic [`WORD_WIDTH-1:0]          id_pc,
    output logic [`WORD_WIDTH-1:0]          id_read1,
    output logic [`WORD_WIDTH-1:0]          id_read2,
    output logic [`WORD_WIDTH-1:0]          id_imm,
    output logic [`WORD_WIDTH-1:0]          id_jumpaddr,
    output logic [1:0]                      id_funct,
    output logic [`REG_ADDR_WIDTH-1:0]      id_write_reg,
    output core_pkg::alu_op_e               id_alu_op,
    output logic                            id_alu_src,
    output logic                            id_branch,
    output logic                            id_reg_write,
    output logic                            id_jump,
    output logic                            id_halt,
    output logic [`REG_ADDR_WIDTH-1:0]      id_rd,
    output logic                            id_rs_valid,
    output logic                            id_rt_valid,
    output logic                            control_zero
);
    import core_pkg::*;

    logic [10:0] jump_off;

    assign rs       = instr.r.rs;
    assign rt       = instr.r.rt;
    assign id_rd    = instr.r.rd;
    assign id_funct = instr.r.funct;
    assign id_pc    = pc;
    assign id_read1 = read1;
    assign id_read2 = read2;

    assign jump_off    = {instr.i.rs, instr.i.rd, instr.i.imm};  // J reads all eleven low bits.
    assign id_imm      = {{(`WORD_WIDTH-5){instr.i.imm[4]}}, instr.i.imm};
    assign id_jumpaddr = {{(`WORD_WIDTH-11){jump_off[10]}}, jump_off};

    assign control_zero = ~instr_valid | redirect;

    always_comb begin
        id_alu_op    = ALU_PASS_B;
        id_alu_src   = 1'b0;
        id_branch    = 1'b0;
        id_reg_write = 1'b0;
        id_jump      = 1'b0;
        id_halt      = 1'b0;
        id_rs_valid  = 1'b0;
        id_rt_valid  = 1'b0;
        id_write_reg = instr.r.rd;
        case (instr.r.opcode)
            `OPC_RTYPE: begin
                id_alu_op    = alu_op_e'({3'b000, instr.r.funct});
                id_reg_write = 1'b1;
                id_rs_valid  = 1'b1;
                id_rt_valid  = 1'b1;
            end
            `OPC_ADDI: begin
                id_alu_op    = ALU_ADD;
                id_alu_src   = 1'b1;
                id_reg_write = 1'b1;
                id_rs_valid  = 1'b1;
                id_write_reg = instr.i.rd;  // Destination sits where R-type keeps rt.
            end
            `OPC_BEQZ: begin
                id_branch   = 1'b1;
                id_rs_valid = 1'b1;
            end
            `OPC_J:    id_jump = 1'b1;
            `OPC_HALT: id_halt = 1'b1;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`WORD_WIDTH-1:0]     ex_pc,
    input  wire logic [`WORD_WIDTH-1:0]     ex_read1,
    input  wire logic [`WORD_WIDTH-1:0]     ex_read2,
    input  wire logic [`WORD_WIDTH-1:0]     ex_imm,
    input  wire logic [`WORD_WIDTH-1:0]     ex_jumpaddr,
    input  wire logic [1:0]                 ex_funct,
    input  wire logic [`REG_ADDR_WIDTH-1:0] ex_write_reg,
    input  core_pkg::alu_op_e               ex_alu_op,
    input  wire logic                       ex_alu_src,
    input  wire logic                       ex_branch,
    input  wire logic                       ex_reg_write,
    input  wire logic                       ex_jump,
    input  wire logic                       ex_halt,
    input  wire logic [`REG_ADDR_WIDTH-1:0] ex_rs,
    input  wire logic [`REG_ADDR_WIDTH-1:0] ex_rt,
    input  wire logic [`REG_ADDR_WIDTH-1:0] ex_rd,
    input  wire logic                       ex_rs_valid,
    input  wire logic                       ex_rt_valid,
    output logic                            redirect,
    output logic [`WORD_WIDTH-1:0]          redirect_pc,
    output logic                            halt_seen,
    output logic                            halted,
    output logic                            retire_valid,
    output logic [`REG_ADDR_WIDTH-1:0]      retire_reg,
    output logic [`WORD_WIDTH-1:0]          retire_data
);
    import core_pkg::*;

    logic [`WORD_WIDTH-1:0] op_a;
    logic [`WORD_WIDTH-1:0] op_b_reg;
    logic [`WORD_WIDTH-1:0] op_b;
    logic [`WORD_WIDTH-1:0] alu_result;
    logic [`WORD_WIDTH-1:0] offset;

    // The previous instruction's result bypasses the register file.
    assign op_a = (ex_rs_valid && retire_valid && retire_reg == ex_rs) ? retire_data : ex_read1;
    assign op_b_reg = (ex_rt_valid && retire_valid && retire_reg == ex_rt) ? retire_data
                                                                           : ex_read2;
    assign op_b = ex_alu_src ? ex_imm : op_b_reg;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            default: alu_result = op_b;
        endcase
    end

    assign offset      = ex_jump ? ex_jumpaddr : ex_imm;
    assign redirect_pc = ex_pc + `WORD_WIDTH'd2 + {offset[`WORD_WIDTH-2:0], 1'b0};
    assign redirect    = ((ex_branch && op_a == '0) || ex_jump) && !halted;
    assign halt_seen   = ex_halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= ex_reg_write & ~halted;  // Nothing behind a halt retires.
            halted       <= halted | ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        retire_reg  <= ex_write_reg;
        retire_data <= alu_result;
    end

    a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
        halted |-> (!redirect && !retire_valid));

    // R-type fields pass decode and ID/EX as one consistent set.
    a_rtype_fields: assert property (@(posedge clk) disable iff (rst)
        (ex_reg_write && !ex_alu_src) |-> (ex_alu_op[1:0] == ex_funct && ex_write_reg == ex_rd));

endmodule

`default_nettype wire

// ==== logic/fetch_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_wb (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   wb_ack,
    input  wire logic [`WORD_WIDTH-1:0] wb_dat_i,
    input  wire logic                   redirect,
    input  wire logic [`WORD_WIDTH-1:0] redirect_pc,
    input  wire logic                   halt_seen,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic [`WORD_WIDTH-1:0]      wb_adr,
    output core_pkg::instr_u            instr,
    output logic                        instr_valid,
    output logic [`WORD_WIDTH-1:0]      pc
);

    logic [`WORD_WIDTH-1:0] fetch_pc;
    logic                   running;
    logic                   stopped;
    logic                   take;

    assign wb_cyc = running & ~halt_seen;  // Drops in the same cycle halt is in execute.
    assign wb_stb = wb_cyc;
    assign wb_adr = fetch_pc;
    assign take   = wb_cyc & wb_ack & ~redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            stopped <= 1'b0;
        end else begin
            stopped <= stopped | halt_seen;
            running <= ~(stopped | halt_seen);  // Once stopped, never restarts.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc    <= `RESET_PC;
            instr_valid <= 1'b0;
        end else if (redirect) begin
            fetch_pc    <= redirect_pc;  // Any ack in this cycle is dropped.
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= take;
            if (take) begin
                fetch_pc <= fetch_pc + `WORD_WIDTH'd2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            instr <= wb_dat_i;
            pc    <= fetch_pc;
        end
    end

    // A request waiting for ack keeps its address unless fetch is redirected or halted.
    a_hold_request: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack && !redirect) |=> (halt_seen || (wb_cyc && $stable(wb_adr))));

endmodule

`default_nettype wire

// ==== logic/idex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module idex_reg (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       control_zero,
    input  wire logic [`WORD_WIDTH-1:0]     id_pc,
    input  wire logic [`WORD_WIDTH-1:0]     id_read1,
    input  wire logic [`WORD_WIDTH-1:0]     id_read2,
    input  wire logic [`WORD_WIDTH-1:0]     id_imm,
    input  wire logic [`WORD_WIDTH-1:0]     id_jumpaddr,
    input  wire logic [1:0]                 id_funct,
    input  wire logic [`REG_ADDR_WIDTH-1:0] id_write_reg,
    input  core_pkg::alu_op_e               id_alu_op,
    input  wire logic                       id_alu_src,
    input  wire logic                       id_branch,
    input  wire logic                       id_reg_write,
    input  wire logic                       id_jump,
    input  wire logic                       id_halt,
    input  wire logic [`REG_ADDR_WIDTH-1:0] id_rs,
    input  wire logic [`REG_ADDR_WIDTH-1:0] id_rt,
    input  wire logic [`REG_ADDR_WIDTH-1:0] id_rd,
    input  wire logic                       id_rs_valid,
    input  wire logic                       id_rt_valid,
    output logic [`WORD_WIDTH-1:0]          ex_pc,
    output logic [`WORD_WIDTH-1:0]          ex_read1,
    output logic [`WORD_WIDTH-1:0]          ex_read2,
    output logic [`WORD_WIDTH-1:0]          ex_imm,
    output logic [`WORD_WIDTH-1:0]          ex_jumpaddr,
    output logic [1:0]                      ex_funct,
    output logic [`REG_ADDR_WIDTH-1:0]      ex_write_reg,
    output core_pkg::alu_op_e               ex_alu_op,
    output logic                            ex_alu_src,
    output logic                            ex_branch,
    output logic                            ex_reg_write,
    output logic                            ex_jump,
    output logic                            ex_halt,
    output logic [`REG_ADDR_WIDTH-1:0]      ex_rs,
    output logic [`REG_ADDR_WIDTH-1:0]      ex_rt,
    output logic [`REG_ADDR_WIDTH-1:0]      ex_rd,
    output logic                            ex_rs_valid,
    output logic                            ex_rt_valid
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_pc        <= '0;
            ex_read1     <= '0;
            ex_read2     <= '0;
            ex_imm       <= '0;
            ex_jumpaddr  <= '0;
            ex_funct     <= '0;
            ex_write_reg <= '0;
            ex_alu_op    <= core_pkg::ALU_ADD;
            ex_alu_src   <= 1'b0;
            ex_branch    <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_jump      <= 1'b0;
            ex_halt      <= 1'b0;
            ex_rs        <= '0;
            ex_rt        <= '0;
            ex_rd        <= '0;
            ex_rs_valid  <= 1'b0;
            ex_rt_valid  <= 1'b0;
        end else begin
            ex_pc        <= id_pc;
            ex_read1     <= id_read1;
            ex_read2     <= id_read2;
            ex_imm       <= id_imm;
            ex_jumpaddr  <= id_jumpaddr;
            ex_funct     <= id_funct;
            ex_write_reg <= id_write_reg;
            ex_alu_op    <= id_alu_op;
            ex_alu_src   <= id_alu_src;
            ex_branch    <= id_branch & ~control_zero;  // A bubble has no side effects.
            ex_reg_write <= id_reg_write & ~control_zero;
            ex_jump      <= id_jump & ~control_zero;
            ex_halt      <= id_halt & ~control_zero;
            ex_rs        <= id_rs;
            ex_rt        <= id_rt;
            ex_rd        <= id_rd;
            ex_rs_valid  <= id_rs_valid;
            ex_rt_valid  <= id_rt_valid;
        end
    end

    // Decode never marks one instruction as both a writer and a halt.
    a_no_write_halt: assert property (@(posedge clk) disable iff (rst)
        !(ex_reg_write && ex_halt));

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module reg_file (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rs,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rt,
    input  wire logic                       we,
    input  wire logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  wire logic [`WORD_WIDTH-1:0]     wdata,
    output logic [`WORD_WIDTH-1:0]          read1,
    output logic [`WORD_WIDTH-1:0]          read2
);

    logic [`WORD_WIDTH-1:0] regs [0:(1<<`REG_ADDR_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through lets decode see the value retiring this cycle.
    assign read1 = (we && waddr == rs) ? wdata : regs[rs];
    assign read2 = (we && waddr == rt) ? wdata : regs[rt];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_core_top -o tb_core_top

./obj_dir/tb_core_top | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

// ==== test/core_stim.txt ====
// Hex entries. @00 holds the program words, @40 the program length, expected retire count,
// halt PC and taken branch count, @48 the taken branch PCs, and @50 the expected retires
// in order, each a register digit followed by four data digits.
@00
4025 415D D94C DA31 DC77   // PC 00-08: ADDI r1=5, ADDI r2=r1-3, ADD r3, SUB r4, XOR r5
DD9A DED8 44E4 6705 DB6D   // PC 0a-12: AND r6, ADD r6+r6, ADDI r7=r4+4, BEQZ r7, SUB r3
6302 47EF 47EF 424F 2003   // PC 14-1c: BEQZ r3 taken, two skipped, ADDI r2+15, J +3
47EF 47EF 47EF DA27 0800   // PC 1e-26: three skipped, XOR r1, NOP
4110 D814 0000 47EF 47EF   // PC 28-30: ADDI r0=r1-16, ADD r5, HALT, two never retired
@40
19   // Program length in words.
D    // Expected retire count.
2C   // Halt PC.
2    // Number of taken branches.
@48
14   // BEQZ r3.
1C   // J.
@50
10005 20002 30007 4FFFD
5FFFA 6FFF8 6FFF0 70001
30000 20011 10014 00004
50008

// ==== test/tb_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_core_top;

    localparam int HALT_LIMIT  = 2000;
    localparam int FETCH_LIMIT = 20;
    localparam int QUIET_LEN   = 50;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic [`WORD_WIDTH-1:0]     wb_adr;
    logic                       wb_ack = 1'b0;
    logic [`WORD_WIDTH-1:0]     wb_dat_i = '0;
    logic                       retire_valid;
    logic [`REG_ADDR_WIDTH-1:0] retire_reg;
    logic [`WORD_WIDTH-1:0]     retire_data;
    logic                       halted;

    logic [19:0] stim_mem [0:127];
    logic [15:0] ack_adr_q [$];
    logic [19:0] retire_q [$];
    logic [16:0] lfsr_state = 17'd97939;
    logic        zero_wait = 1'b1;
    logic        busy = 1'b0;
    logic [1:0]  wait_left = 2'd0;
    logic [15:0] halt_pc;
    int          prog_len;
    int          exp_retires;
    int          taken_count;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #2 clk = ~clk;

    core_top i_core_top (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_ack(wb_ack), .wb_dat_i(wb_dat_i),
        .retire_valid(retire_valid), .retire_reg(retire_reg),
        .retire_data(retire_data), .halted(halted)
    );

    // Taps 17 and 14 give a maximal length sequence.
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [1:0] draw_wait_states();
        logic [1:0] v;
        lfsr_state = lfsr_step(lfsr_state);
        v[0] = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        v[1] = lfsr_state[0];
        return (v == 2'd3) ? 2'd2 : v;  // Folded into 0 to 2 wait states.
    endfunction

    function automatic logic [19:0] stim_at(input int idx);
        return stim_mem[idx[6:0]];
    endfunction

    function automatic logic [15:0] mem_word(input logic [15:0] adr);
        if (int'(adr[15:1]) < prog_len) begin
            return stim_mem[adr[7:1]][15:0];
        end
        return {`OPC_NOP, adr[10:0] ^ {6'd0, adr[15:11]}};  // NOP fill past the program.
    endfunction

    // The Wishbone slave answers the request seen just after each rising edge.
    always @(posedge clk) begin
        #0.5;
        if (rst || !wb_cyc || !wb_stb) begin
            busy   = 1'b0;
            wb_ack = 1'b0;
        end else begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = zero_wait ? 2'd0 : draw_wait_states();
            end
            if (wait_left == 2'd0) begin
                busy     = 1'b0;
                wb_ack   = 1'b1;
                wb_dat_i = mem_word(wb_adr);
            end else begin
                wb_ack    = 1'b0;
                wait_left = wait_left - 2'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (wb_stb && !wb_cyc) begin
            $display("Error at %0t: wb_stb is high while wb_cyc is low", $time);
            test_errors++;
        end
        if (rst) begin
            ack_adr_q.delete();
            retire_q.delete();
        end else begin
            if (wb_cyc && wb_stb && wb_ack) begin
                ack_adr_q.push_back(wb_adr);
            end
            if (retire_valid) begin
                retire_q.push_back({1'b0, retire_reg, retire_data});
            end
        end
    end

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS: %s", name);
        end else begin
            $display("FAIL: %s (%0d errors)", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #0.5;
        rst = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (i > 0 && (wb_cyc || retire_valid || halted)) begin
                $display("Mismatch at %0t: outputs not idle in reset cyc=%b ret=%b halted=%b",
                         $time, wb_cyc, retire_valid, halted);
                test_errors++;
            end
        end
        @(posedge clk);
        #0.5;
        rst = 1'b0;
    endtask

    task automatic await_first_fetch();
        int n;
        n = 0;
        while (!wb_cyc && n < FETCH_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_cyc) begin
            $display("Timeout at %0t: fetch never started after reset", $time);
            test_errors++;
        end else if (wb_adr != `RESET_PC) begin
            $display("Mismatch at %0t: first wb_adr expected %h got %h", $time, `RESET_PC,
                     wb_adr);
            test_errors++;
        end
    endtask

    task automatic run_to_halt();
        int n;
        logic found;
        n = 0;
        found = 1'b0;
        while (!halted && n < HALT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("Timeout at %0t: the core never halted", $time);
            test_errors++;
        end
        for (int i = 0; i < QUIET_LEN; i++) begin
            @(negedge clk);
            if (wb_cyc || wb_stb || !halted) begin
                $display("Mismatch at %0t: after halt cyc=%b stb=%b halted=%b", $time,
                         wb_cyc, wb_stb, halted);
                test_errors++;
            end
        end
        foreach (ack_adr_q[i]) begin
            if (ack_adr_q[i] == halt_pc) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Error at %0t: the HALT at %h was never fetched", $time, halt_pc);
            test_errors++;
        end else if (ack_adr_q[$] != halt_pc && ack_adr_q[$] != halt_pc + 16'd2) begin
            $display("Mismatch at %0t: last fetch expected %h got %h", $time, halt_pc,
                     ack_adr_q[$]);
            test_errors++;
        end
        if (retire_q.size() != exp_retires) begin
            $display("Mismatch at %0t: retire count expected %0d got %0d", $time, exp_retires,
                     retire_q.size());
            test_errors++;
        end
    endtask

    task automatic compare_retires();
        logic [19:0] exp_e;
        logic [19:0] got_e;
        for (int i = 0; i < exp_retires && i < retire_q.size(); i++) begin
            exp_e = stim_at(80 + i);
            got_e = retire_q[i];
            if (got_e != exp_e) begin
                $display("Mismatch at %0t: retire %0d expected r%0d=%h got r%0d=%h", $time, i,
                         exp_e[18:16], exp_e[15:0], got_e[18:16], got_e[15:0]);
                test_errors++;
            end
        end
    endtask

    task automatic verify_redirects();
        logic [19:0] entry;
        logic [15:0] bpc;
        logic [15:0] word;
        logic [15:0] offset;
        logic [15:0] target;
        logic [15:0] next_seq;
        int          pos;
        for (int b = 0; b < taken_count; b++) begin
            entry = stim_at(72 + b);
            bpc   = entry[15:0];
            word  = mem_word(bpc);
            if (word[15:11] == `OPC_J) begin
                offset = {{5{word[10]}}, word[10:0]};
            end else begin
                offset = {{11{word[4]}}, word[4:0]};
            end
            target   = bpc + 16'd2 + {offset[14:0], 1'b0};
            next_seq = bpc + 16'd2;
            pos      = -1;
            for (int i = 0; i < ack_adr_q.size(); i++) begin
                if (pos < 0 && ack_adr_q[i] == bpc) begin
                    pos = i;
                end
            end
            if (pos < 0) begin
                $display("Error at %0t: the branch at %h was never fetched", $time, bpc);
                test_errors++;
            end else begin
                pos++;
                // At most two sequential words may be fetched before the target.
                while (pos < ack_adr_q.size() && next_seq != bpc + 16'd6 &&
                       ack_adr_q[pos] == next_seq) begin
                    pos++;
                    next_seq = next_seq + 16'd2;
                end
                if (pos >= ack_adr_q.size()) begin
                    $display("Error at %0t: nothing was fetched after the branch at %h",
                             $time, bpc);
                    test_errors++;
                end else if (ack_adr_q[pos] != target) begin
                    $display("Mismatch at %0t: fetch after branch at %h expected %h got %h",
                             $time, bpc, target, ack_adr_q[pos]);
                    test_errors++;
                end
            end
        end
    endtask

    initial begin
        string mode;
        $readmemh("test/core_stim.txt", stim_mem);
        prog_len    = int'(stim_mem[64]);
        exp_retires = int'(stim_mem[65]);
        halt_pc     = stim_mem[66][15:0];
        taken_count = int'(stim_mem[67]);
        for (int run = 0; run < 2; run++) begin
            zero_wait = (run == 0);
            mode = zero_wait ? "zero-wait" : "random-wait";
            apply_reset();
            await_first_fetch();
            close_test({"reset state, ", mode});
            run_to_halt();
            close_test({"halt, ", mode});
            compare_retires();
            close_test({"retire sequence, ", mode});
            verify_redirects();
            close_test({"branch and jump redirects, ", mode});
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
logic/core_pkg.sv
logic/fetch_wb.sv
logic/decode.sv
logic/reg_file.sv
logic/idex_reg.sv
logic/execute.sv
logic/core_top.sv
test/tb_core_top.sv
